/* include/yolo_write_defs.svh */
`ifndef YOLO_WRITE_DEFS_SVH
`define YOLO_WRITE_DEFS_SVH

// bus and field widths
`define YOLO_APB_ADDR_W 6
`define YOLO_DATA_W 32
`define YOLO_IO_ADDR_W 32
`define YOLO_OFFSET_W 16
`define YOLO_LEN_W 8
`define YOLO_PERIOD_W 10

// internal buffer address, top bit is the ping-pong bank
`define YOLO_MEM_ADDR_W 10

`define YOLO_N_STAGES 4

// apb register byte offsets
`define YOLO_REG_EXT_ADDR 6'h00
`define YOLO_REG_OFFSET 6'h04
`define YOLO_REG_LEN 6'h08
`define YOLO_REG_START 6'h0C
`define YOLO_REG_ITER 6'h10
`define YOLO_REG_PER 6'h14
`define YOLO_REG_SHIFT 6'h18
`define YOLO_REG_INCR 6'h1C
// read only, bit 0 busy, bit 1 done
`define YOLO_REG_STATUS 6'h20

`endif

/* tb/yolo_write_ctrl_assert.sv */
`timescale 1ns/10ps

module yolo_write_ctrl_assert (
   input logic clk,
   input logic rst,
   input logic psel,
   input logic pready,
   input logic addr_en,
   input logic done
);

   int fail_count = 0;

   // zero wait state slave
   apb_ready: assert property (@(posedge clk) disable iff (rst) psel |-> pready)
      else begin
         $error("pready low while psel is high");
         fail_count++;
      end

   no_addr_after_done: assert property (@(posedge clk) disable iff (rst) !(addr_en && done))
      else begin
         $error("addr_en high while done is high");
         fail_count++;
      end

   quiet_in_reset: assert property (@(posedge clk) rst |-> (!addr_en && !done))
      else begin
         $error("done or addr_en high during reset");
         fail_count++;
      end

endmodule

bind yolo_write_ctrl yolo_write_ctrl_assert u_assert (
   .clk     (clk),
   .rst     (rst),
   .psel    (psel),
   .pready  (pready),
   .addr_en (addr_en),
   .done    (done)
);

/* tb/yolo_write_ctrl_tb.sv */
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module yolo_write_ctrl_tb
   import yolo_pkg::*;
();

   localparam int AW = `YOLO_APB_ADDR_W;
   localparam int DW = `YOLO_DATA_W;
   localparam int MW = `YOLO_MEM_ADDR_W;
   localparam int PW = `YOLO_PERIOD_W;
   localparam int NS = `YOLO_N_STAGES;

   logic           clk;
   logic           rst;
   logic           clear;
   logic           run;
   logic [AW-1:0]  paddr;
   logic           psel;
   logic           penable;
   logic           pwrite;
   logic [DW-1:0]  pwdata;
   logic [DW-1:0]  prdata;
   logic           pready;
   logic           pslverr;
   mem_addr_t      addr;
   logic           addr_en;
   logic           done;
   stage_addr_t    stage_addr;
   len_t           dma_len;

   // register model, index is byte offset / 4
   // ext_addr, offset, len, start, iter, per, shift, incr
   logic [DW-1:0]  model [8];
   logic           exp_bank;
   stage_addr_t    exp_stage;
   len_t           exp_len;
   logic [15:0]    lfsr = 16'd92;
   int             n_value_err;
   int             n_other_err;
   int             n_assert_err;

   yolo_write_ctrl UUT (
      .clk        (clk),
      .rst        (rst),
      .clear      (clear),
      .run        (run),
      .paddr      (paddr),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .addr       (addr),
      .addr_en    (addr_en),
      .done       (done),
      .stage_addr (stage_addr),
      .dma_len    (dma_len)
   );

   always #2 clk = ~clk;

   // galois lfsr, one step per bit
   function automatic logic [DW-1:0] rand_bits(input int n);
      logic [DW-1:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         v = {v[DW-2:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [DW-1:0] reg_mask(input int idx);
      int w;
      case (idx)
         0: w = `YOLO_IO_ADDR_W;
         1: w = 16;
         2: w = `YOLO_LEN_W;
         3: w = MW - 1;
         4, 5: w = PW;
         default: w = MW;
      endcase
      return DW'((64'd1 << w) - 64'd1);
   endfunction

   task automatic check_mem_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
      if (act !== exp) begin
         n_value_err++;
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_io_addr(input string name, input io_addr_t exp, input io_addr_t act);
      if (act !== exp) begin
         n_value_err++;
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_len(input string name, input len_t exp, input len_t act);
      if (act !== exp) begin
         n_value_err++;
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_data(input string name, input logic [DW-1:0] exp, input logic [DW-1:0] act);
      if (act !== exp) begin
         n_value_err++;
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         n_value_err++;
         $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timeout at %0t ns while waiting for %s", $time, what);
      $display("** FAIL **");
      $finish;
   endtask

   task automatic apb_access(input logic wr, input logic [AW-1:0] a, input logic [DW-1:0] wd,
                             output logic [DW-1:0] rd, output logic err);
      int t;
      @(negedge clk);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = wr;
      paddr = a;
      pwdata = wd;
      @(negedge clk);
      penable = 1'b1;
      t = 0;
      // access phase, sampled before the closing edge
      #1;
      while (pready !== 1'b1) begin
         t++;
         if (t > 16)
            abort_on_timeout("pready");
         @(negedge clk);
         #1;
      end
      rd = prdata;
      err = pslverr;
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic apb_write(input logic [AW-1:0] a, input logic [DW-1:0] d, input logic exp_err);
      logic [DW-1:0] rd;
      logic err;
      apb_access(1'b1, a, d, rd, err);
      check_flag($sformatf("pslverr on write %h", a), exp_err, err);
   endtask

   task automatic apb_read(input logic [AW-1:0] a, input logic [DW-1:0] exp, input logic exp_err);
      logic [DW-1:0] rd;
      logic err;
      apb_access(1'b0, a, '0, rd, err);
      check_flag($sformatf("pslverr on read %h", a), exp_err, err);
      if (!exp_err)
         check_data($sformatf("prdata at %h", a), exp, rd);
   endtask

   task automatic set_reg(input int idx, input logic [DW-1:0] d);
      apb_write(AW'(idx * 4), d, 1'b0);
      model[idx] = d & reg_mask(idx);
   endtask

   task automatic check_all_regs();
      for (int i = 0; i < 8; i++) begin
         apb_read(AW'(i * 4), model[i], 1'b0);
      end
   endtask

   task automatic load_addrgen(input int n_iter, input int n_per);
      set_reg(3, rand_bits(MW - 1));
      set_reg(4, n_iter);
      set_reg(5, n_per);
      set_reg(6, rand_bits(MW));
      set_reg(7, rand_bits(MW));
   endtask

   task automatic check_stage_outputs();
      for (int i = 0; i < NS; i++) begin
         check_io_addr($sformatf("stage_addr[%0d]", i), exp_stage[i], stage_addr[i]);
      end
      check_len("dma_len", exp_len, dma_len);
   endtask

   task automatic run_pulse();
      @(negedge clk);
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
   endtask

   // one run, stream checked against the expected address sequence
   // busy_run sends a second run pulse in the middle of the stream
   task automatic run_stream(input bit busy_run);
      mem_addr_t exp_q[$];
      mem_addr_t acc;
      int idx;
      int t;
      bit fired;
      exp_bank = ~exp_bank;
      acc = mem_addr_t'(model[3]);
      for (int it = 0; it < model[4]; it++) begin
         for (int p = 0; p < model[5]; p++) begin
            exp_q.push_back({exp_bank, acc[MW-2:0]});
            acc = acc + ((p == model[5] - 1) ? mem_addr_t'(model[6]) : mem_addr_t'(model[7]));
         end
      end
      for (int i = 0; i < NS; i++) begin
         exp_stage[i] = io_addr_t'(model[0] + i * model[1]);
      end
      exp_len = len_t'(model[2]);
      run_pulse();
      @(negedge clk);
      idx = 0;
      t = 0;
      fired = 0;
      while (done !== 1'b1) begin
         if (addr_en === 1'b1) begin
            if (idx < exp_q.size())
               check_mem_addr($sformatf("addr #%0d", idx), exp_q[idx], addr);
            idx++;
         end
         run = busy_run && idx == 2 && !fired;
         if (run)
            fired = 1;
         t++;
         if (t > 200)
            abort_on_timeout("done after a run");
         @(negedge clk);
      end
      run = 1'b0;
      if (idx != exp_q.size()) begin
         n_other_err++;
         $display("run produced %0d addresses instead of %0d", idx, exp_q.size());
      end
      check_stage_outputs();
   endtask

   task automatic reset_state();
      check_flag("done", 1'b0, done);
      check_flag("addr_en", 1'b0, addr_en);
      check_stage_outputs();
      check_all_regs();
      apb_read(`YOLO_REG_STATUS, '0, 1'b0);
   endtask

   task automatic register_access();
      for (int i = 0; i < 8; i++) begin
         set_reg(i, rand_bits(DW));
      end
      check_all_regs();
      apb_write(6'h24, rand_bits(DW), 1'b1);
      apb_read(6'h3C, '0, 1'b1);
      apb_write(`YOLO_REG_STATUS, '1, 1'b1);
      check_all_regs();
      apb_read(`YOLO_REG_STATUS, '0, 1'b0);
   endtask

   task automatic address_stream();
      load_addrgen(rand_bits(2) + 1, rand_bits(3) % 5 + 1);
      run_stream(1'b0);
      // done set, busy clear
      apb_read(`YOLO_REG_STATUS, 32'h2, 1'b0);
      load_addrgen(rand_bits(2) + 1, rand_bits(3) % 5 + 1);
      run_stream(1'b0);
   endtask

   task automatic stage_rewrite();
      int t;
      set_reg(0, rand_bits(DW));
      set_reg(1, rand_bits(DW));
      set_reg(2, rand_bits(DW));
      load_addrgen(4, 5);
      fork
         run_stream(1'b0);
         begin
            t = 0;
            while (addr_en !== 1'b1) begin
               t++;
               if (t > 50)
                  abort_on_timeout("first addr_en");
               @(negedge clk);
            end
            for (int i = 0; i < 8; i++) begin
               set_reg(i, rand_bits(DW));
            end
         end
      join
      check_stage_outputs();
   endtask

   task automatic busy_and_empty();
      load_addrgen(2, 4);
      run_stream(1'b1);
      // bank must not have flipped for the ignored pulse
      load_addrgen(1, 1);
      run_stream(1'b0);
      load_addrgen(0, 3);
      run_stream(1'b0);
   endtask

   task automatic clear_config();
      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      for (int i = 0; i < 8; i++) begin
         model[i] = '0;
      end
      check_all_regs();
      check_stage_outputs();
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      clear = 1'b0;
      run = 1'b0;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      exp_bank = 1'b0;
      exp_stage = '0;
      exp_len = '0;
      n_value_err = 0;
      n_other_err = 0;
      n_assert_err = 0;
      for (int i = 0; i < 8; i++) begin
         model[i] = '0;
      end
      repeat (4) @(negedge clk);
      rst = 1'b0;
      reset_state();
      register_access();
      address_stream();
      stage_rewrite();
      busy_and_empty();
      clear_config();
      n_assert_err = UUT.u_assert.fail_count;
      $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
               n_value_err, n_other_err, n_assert_err);
      if (n_value_err == 0 && n_other_err == 0 && n_assert_err == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* verilog/yolo_addr_gen.sv */
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module yolo_addr_gen
   import yolo_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          start_run,
   input  addrgen_cfg_t  cfg,
   output mem_addr_t     addr,
   output logic          addr_en,
   output logic          busy,
   output logic          done
);

   logic       armed;
   logic       bank;
   logic       last_per;
   logic       last_iter;
   period_t    per_cnt;
   period_t    iter_cnt;
   mem_addr_t  acc;

   assign last_per = (per_cnt == cfg.per - period_t'(1));
   assign last_iter = (iter_cnt == cfg.iter - period_t'(1));

   // bank bit replaces the top address bit
   assign addr = {bank, acc[`YOLO_MEM_ADDR_W-2:0]};

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         armed <= 1'b0;
         bank <= 1'b0;
         busy <= 1'b0;
         done <= 1'b0;
         addr_en <= 1'b0;
         per_cnt <= '0;
         iter_cnt <= '0;
         acc <= '0;
      end else begin
         // shadow is loaded on the same edge, use it one cycle later
         armed <= start_run;
         if (start_run) begin
            bank <= ~bank;
         end

         if (armed) begin
            busy <= 1'b1;
            done <= 1'b0;
            addr_en <= (cfg.iter != '0) && (cfg.per != '0);
            acc <= {1'b0, cfg.start};
            per_cnt <= '0;
            iter_cnt <= '0;
         end else if (addr_en) begin
            if (last_per) begin
               per_cnt <= '0;
               iter_cnt <= iter_cnt + period_t'(1);
               acc <= acc + cfg.shift;
               if (last_iter) begin
                  addr_en <= 1'b0;
                  busy <= 1'b0;
                  done <= 1'b1;
               end
            end else begin
               per_cnt <= per_cnt + period_t'(1);
               acc <= acc + cfg.incr;
            end
         end else if (busy) begin
            // empty stream, finish right away
            busy <= 1'b0;
            done <= 1'b1;
         end
      end
   end

endmodule

/* verilog/yolo_cfg_apb.sv */
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module yolo_cfg_apb
   import yolo_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clear,
   input  logic [`YOLO_APB_ADDR_W-1:0]  paddr,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [`YOLO_DATA_W-1:0]      pwdata,
   input  logic                         busy,
   input  logic                         done,
   output logic [`YOLO_DATA_W-1:0]      prdata,
   output logic                         pready,
   output logic                         pslverr,
   output addrgen_cfg_t                 addrgen_cfg,
   output ext_cfg_t                     ext_cfg
);

   localparam int DATA_W = `YOLO_DATA_W;

   logic                access;
   logic                mapped;
   logic                status_sel;
   logic                wr_en;
   logic [DATA_W-1:0]   rd_data;

   // no wait states
   assign pready = 1'b1;

   assign access = psel & penable;
   assign status_sel = (paddr == `YOLO_REG_STATUS);

   // readback mux, fields zero extended
   always_comb begin
      rd_data = '0;
      mapped = 1'b1;
      case (paddr)
         `YOLO_REG_EXT_ADDR: rd_data = DATA_W'(ext_cfg.ext_addr);
         `YOLO_REG_OFFSET:   rd_data = DATA_W'(ext_cfg.offset);
         `YOLO_REG_LEN:      rd_data = DATA_W'(ext_cfg.len);
         `YOLO_REG_START:    rd_data = DATA_W'(addrgen_cfg.start);
         `YOLO_REG_ITER:     rd_data = DATA_W'(addrgen_cfg.iter);
         `YOLO_REG_PER:      rd_data = DATA_W'(addrgen_cfg.per);
         `YOLO_REG_SHIFT:    rd_data = DATA_W'(addrgen_cfg.shift);
         `YOLO_REG_INCR:     rd_data = DATA_W'(addrgen_cfg.incr);
         `YOLO_REG_STATUS:   rd_data = DATA_W'({done, busy});
         default:            mapped = 1'b0;
      endcase
   end

   assign prdata = rd_data;

   // unmapped offset or write to status
   assign pslverr = access & (~mapped | (pwrite & status_sel));

   assign wr_en = access & pwrite & mapped & ~status_sel;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         addrgen_cfg <= '0;
         ext_cfg <= '0;
      end else if (clear) begin
         addrgen_cfg <= '0;
         ext_cfg <= '0;
      end else if (wr_en) begin
         case (paddr)
            `YOLO_REG_EXT_ADDR: ext_cfg.ext_addr <= pwdata[`YOLO_IO_ADDR_W-1:0];
            `YOLO_REG_OFFSET:   ext_cfg.offset <= pwdata[`YOLO_OFFSET_W-1:0];
            `YOLO_REG_LEN:      ext_cfg.len <= pwdata[`YOLO_LEN_W-1:0];
            `YOLO_REG_START:    addrgen_cfg.start <= pwdata[`YOLO_MEM_ADDR_W-2:0];
            `YOLO_REG_ITER:     addrgen_cfg.iter <= pwdata[`YOLO_PERIOD_W-1:0];
            `YOLO_REG_PER:      addrgen_cfg.per <= pwdata[`YOLO_PERIOD_W-1:0];
            `YOLO_REG_SHIFT:    addrgen_cfg.shift <= pwdata[`YOLO_MEM_ADDR_W-1:0];
            `YOLO_REG_INCR:     addrgen_cfg.incr <= pwdata[`YOLO_MEM_ADDR_W-1:0];
            default: begin
            end
         endcase
      end
   end

endmodule

/* verilog/yolo_cfg_shadow.sv */
`timescale 1ns/10ps

module yolo_cfg_shadow #(
   parameter type cfg_t = logic
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  run,
   input  logic  busy,
   input  cfg_t  cfg_in,
   output cfg_t  cfg_out,
   output logic  accept
);

   // a run during an active layer is dropped
   assign accept = run & ~busy;

   // live registers may be rewritten once this copy is taken
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         cfg_out <= '0;
      end else if (accept) begin
         cfg_out <= cfg_in;
      end
   end

endmodule

/* verilog/yolo_pkg.sv */
`include "yolo_write_defs.svh"

package yolo_pkg;

   // scalar types
   typedef logic [`YOLO_IO_ADDR_W-1:0] io_addr_t;
   typedef logic [`YOLO_MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [`YOLO_PERIOD_W-1:0] period_t;
   typedef logic [`YOLO_LEN_W-1:0] len_t;

   // internal address generator setup
   // start has no bank bit, the generator supplies it
   typedef struct packed {
      logic [`YOLO_MEM_ADDR_W-2:0] start;
      period_t iter;
      period_t per;
      mem_addr_t shift;
      mem_addr_t incr;
   } addrgen_cfg_t;

   // external memory setup
   typedef struct packed {
      io_addr_t ext_addr;
      logic [`YOLO_OFFSET_W-1:0] offset;
      len_t len;
   } ext_cfg_t;

   // one external base address per stage
   typedef io_addr_t [`YOLO_N_STAGES-1:0] stage_addr_t;

endpackage

/* verilog/yolo_stage_addr.sv */
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module yolo_stage_addr
   import yolo_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         load,
   input  ext_cfg_t     cfg,
   output stage_addr_t  stage_addr,
   output len_t         dma_len
);

   logic         load_q;
   stage_addr_t  stage_next;

   // base plus stage index times offset, wraps at 32 bits
   genvar i;
   generate
      for (i = 0; i < `YOLO_N_STAGES; i++) begin : g_stage
         assign stage_next[i] = cfg.ext_addr + io_addr_t'(i) * io_addr_t'(cfg.offset);
      end
   endgenerate

   // cfg is the shadow copy, valid the cycle after load
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         load_q <= 1'b0;
         stage_addr <= '0;
         dma_len <= '0;
      end else begin
         load_q <= load;
         if (load_q) begin
            stage_addr <= stage_next;
            dma_len <= cfg.len;
         end
      end
   end

endmodule

/* verilog/yolo_write_ctrl.sv */
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module yolo_write_ctrl
   import yolo_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clear,
   input  logic                         run,
   input  logic [`YOLO_APB_ADDR_W-1:0]  paddr,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [`YOLO_DATA_W-1:0]      pwdata,
   output logic [`YOLO_DATA_W-1:0]      prdata,
   output logic                         pready,
   output logic                         pslverr,
   output mem_addr_t                    addr,
   output logic                         addr_en,
   output logic                         done,
   output stage_addr_t                  stage_addr,
   output len_t                         dma_len
);

   addrgen_cfg_t  addrgen_cfg_live;
   addrgen_cfg_t  addrgen_cfg_sh;
   ext_cfg_t      ext_cfg_live;
   ext_cfg_t      ext_cfg_sh;
   logic          accept;
   logic          busy;

   yolo_cfg_apb u_cfg_apb (
      .clk         (clk),
      .rst         (rst),
      .clear       (clear),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .busy        (busy),
      .done        (done),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .addrgen_cfg (addrgen_cfg_live),
      .ext_cfg     (ext_cfg_live)
   );

   // this instance owns the accept pulse
   yolo_cfg_shadow #(.cfg_t(addrgen_cfg_t)) u_addrgen_shadow (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .busy    (busy),
      .cfg_in  (addrgen_cfg_live),
      .cfg_out (addrgen_cfg_sh),
      .accept  (accept)
   );

   yolo_cfg_shadow #(.cfg_t(ext_cfg_t)) u_ext_shadow (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .busy    (busy),
      .cfg_in  (ext_cfg_live),
      .cfg_out (ext_cfg_sh),
      .accept  ()
   );

   yolo_addr_gen u_addr_gen (
      .clk       (clk),
      .rst       (rst),
      .start_run (accept),
      .cfg       (addrgen_cfg_sh),
      .addr      (addr),
      .addr_en   (addr_en),
      .busy      (busy),
      .done      (done)
   );

   yolo_stage_addr u_stage_addr (
      .clk        (clk),
      .rst        (rst),
      .load       (accept),
      .cfg        (ext_cfg_sh),
      .stage_addr (stage_addr),
      .dma_len    (dma_len)
   );

endmodule

/* yolo_write_ctrl.f */
+incdir+include
verilog/yolo_pkg.sv
verilog/yolo_cfg_apb.sv
verilog/yolo_cfg_shadow.sv
verilog/yolo_addr_gen.sv
verilog/yolo_stage_addr.sv
verilog/yolo_write_ctrl.sv
tb/yolo_write_ctrl_assert.sv
tb/yolo_write_ctrl_tb.sv
